// ==== design/histPkg.sv ====
package histPkg;

    // pixel array geometry
    localparam int PIXEL_NUM = 4;
    localparam int BIN_NUM = 16;
    localparam int PIXEL_W = $clog2(PIXEL_NUM);
    localparam int BIN_W = $clog2(BIN_NUM);

    // memory address is pixel index followed by bin index
    localparam int ADDR_W = PIXEL_W + BIN_W;
    localparam int MEM_DEPTH = PIXEL_NUM * BIN_NUM;

    // per-bin photon count, saturating
    localparam int COUNT_W = 8;
    localparam logic [COUNT_W-1:0] COUNT_MAX = '1;

    // input word and marker tag
    localparam int WORD_W = 12;
    localparam int TAG_W = 8;

    // padding between kind flag and payload in each view
    localparam int EVT_PAD_W = WORD_W - 1 - PIXEL_W - BIN_W;
    localparam int MRK_PAD_W = WORD_W - 1 - TAG_W;

    // kind flag, msb of both views
    localparam logic KIND_EVENT = 1'b0;
    localparam logic KIND_MARKER = 1'b1;

    // one input word, decoded as photon event or frame-end marker
    typedef union packed {
        // photon hit on a pixel in one time bin
        struct packed {
            logic                 kind;
            logic [EVT_PAD_W-1:0] unused;
            logic [PIXEL_W-1:0]   pixel;
            logic [BIN_W-1:0]     bin;
        } eventView;
        // end of frame, tag echoed with the peaks
        struct packed {
            logic                 kind;
            logic [MRK_PAD_W-1:0] unused;
            logic [TAG_W-1:0]     tag;
        } markerView;
    } histWord;

endpackage

// ==== design/eventDecoder.sv ====
`timescale 1ns/1ns

module eventDecoder import histPkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic              dataValid,
    input  histWord           dataIn,
    input  logic              busy,
    output logic              incValid,
    output logic [ADDR_W-1:0] incAddr,
    output logic              frameValid,
    output logic [TAG_W-1:0]  frameTag
);

    logic accept;
    logic isEvent;
    logic isMarker;

    // words are dropped while the memory is being cleared
    assign accept = dataValid && !busy;

    // kind bit is shared, read through each view
    assign isEvent = (dataIn.eventView.kind == KIND_EVENT);
    assign isMarker = (dataIn.markerView.kind == KIND_MARKER);

    // strobes, one cycle after the input strobe
    always_ff @(posedge clk) begin
        if (!rstN) begin
            incValid <= 1'b0;
            frameValid <= 1'b0;
        end else begin
            incValid <= accept && isEvent;
            frameValid <= accept && isMarker;
        end
    end

    // payload only loaded with its strobe
    always_ff @(posedge clk) begin
        if (accept && isEvent) begin
            // pixel in the upper bits, bin in the lower
            incAddr <= {dataIn.eventView.pixel, dataIn.eventView.bin};
        end
        if (accept && isMarker) begin
            frameTag <= dataIn.markerView.tag;
        end
    end

endmodule

// ==== design/histRam.sv ====
`timescale 1ns/1ns

module histRam import histPkg::*; (
    input  logic               clk,
    input  logic               rdEn,
    input  logic [ADDR_W-1:0]  rdAddr,
    output logic [COUNT_W-1:0] rdData,
    input  logic               wrEn,
    input  logic [ADDR_W-1:0]  wrAddr,
    input  logic [COUNT_W-1:0] wrData
);

    // one count per pixel and bin
    logic [COUNT_W-1:0] mem [MEM_DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // registered read port
    // same-cycle write to the same address returns old data,
    // the accumulator forwards around that
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

// ==== design/binAccumulator.sv ====
`timescale 1ns/1ns

module binAccumulator import histPkg::*; (
    input  logic               clk,
    input  logic               rstN,
    input  logic               incValid,
    input  logic [ADDR_W-1:0]  incAddr,
    input  logic               frameValid,
    output logic               rdEn,
    output logic [ADDR_W-1:0]  rdAddr,
    input  logic [COUNT_W-1:0] rdData,
    output logic               wrEn,
    output logic [ADDR_W-1:0]  wrAddr,
    output logic [COUNT_W-1:0] wrData,
    output logic               updValid,
    output logic [ADDR_W-1:0]  updAddr,
    output logic [COUNT_W-1:0] updCount,
    output logic               busy
);

    // request waiting for its read data
    logic               reqValid;
    logic [ADDR_W-1:0]  reqAddr;
    // last increment written, for back-to-back hits
    logic               fwdValid;
    logic [ADDR_W-1:0]  fwdAddr;
    logic [COUNT_W-1:0] fwdCount;
    // clear sweep control
    logic               drainStep;
    logic               clearing;
    logic [ADDR_W-1:0]  clearAddr;
    logic [COUNT_W-1:0] baseCount;
    logic [COUNT_W-1:0] newCount;

    // read issued in the same cycle as the request
    assign rdEn = incValid;
    assign rdAddr = incAddr;

    // memory still holds the old value if the previous write hit this address
    assign baseCount = (fwdValid && fwdAddr == reqAddr) ? fwdCount : rdData;
    // hold at full scale
    assign newCount = (baseCount == COUNT_MAX) ? baseCount : baseCount + 1'b1;

    // write port shared by increments and the clear sweep
    assign wrEn = reqValid || clearing;
    assign wrAddr = clearing ? clearAddr : reqAddr;
    assign wrData = clearing ? '0 : newCount;

    // every completed increment goes to the peak tracker
    assign updValid = reqValid;
    assign updAddr = reqAddr;
    assign updCount = newCount;

    // high from the marker strobe until the last address is cleared
    assign busy = frameValid || drainStep || clearing;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            reqValid <= 1'b0;
            fwdValid <= 1'b0;
            drainStep <= 1'b0;
            clearing <= 1'b0;
            clearAddr <= '0;
        end else begin
            reqValid <= incValid;
            fwdValid <= reqValid;
            // one cycle gap so the last increment lands first
            drainStep <= frameValid;
            if (drainStep) begin
                clearing <= 1'b1;
            end else if (clearing && clearAddr == ADDR_W'(MEM_DEPTH - 1)) begin
                clearing <= 1'b0;
            end
            // counter wraps back to zero on the last address
            if (clearing) begin
                clearAddr <= clearAddr + 1'b1;
            end
        end
    end

    // payload side, no reset
    always_ff @(posedge clk) begin
        reqAddr <= incAddr;
        fwdAddr <= reqAddr;
        fwdCount <= newCount;
    end

endmodule

// ==== design/peakTracker.sv ====
`timescale 1ns/1ns

module peakTracker import histPkg::*; (
    input  logic               clk,
    input  logic               rstN,
    input  logic               updValid,
    input  logic [ADDR_W-1:0]  updAddr,
    input  logic [COUNT_W-1:0] updCount,
    input  logic               frameValid,
    input  logic [TAG_W-1:0]   frameTag,
    output logic               peakValid,
    output logic [PIXEL_W-1:0] peakPixel,
    output logic [BIN_W-1:0]   peakBin,
    output logic [COUNT_W-1:0] peakCount,
    output logic [TAG_W-1:0]   peakFrame
);

    // best bin and its count, per pixel
    logic [BIN_W-1:0]   bestBin [PIXEL_NUM];
    logic [COUNT_W-1:0] bestCount [PIXEL_NUM];
    logic [PIXEL_W-1:0] updPixel;
    logic [BIN_W-1:0]   updBin;
    // frame-end sequence
    logic               draining;
    logic               emitting;
    logic [PIXEL_W-1:0] emitPixel;
    logic [TAG_W-1:0]   tagReg;

    assign updPixel = updAddr[ADDR_W-1 -: PIXEL_W];
    assign updBin = updAddr[BIN_W-1:0];

    // one pixel per cycle while emitting
    assign peakValid = emitting;
    assign peakPixel = emitPixel;
    assign peakBin = bestBin[emitPixel];
    assign peakCount = bestCount[emitPixel];
    assign peakFrame = tagReg;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            draining <= 1'b0;
            emitting <= 1'b0;
            emitPixel <= '0;
            for (int i = 0; i < PIXEL_NUM; i++) begin
                bestBin[i] <= '0;
                bestCount[i] <= '0;
            end
        end else begin
            // marker cycle plus one more lets the last update settle
            draining <= frameValid;
            if (draining) begin
                emitting <= 1'b1;
                emitPixel <= '0;
            end else if (emitting) begin
                emitPixel <= emitPixel + 1'b1;
                if (emitPixel == PIXEL_W'(PIXEL_NUM - 1)) begin
                    emitting <= 1'b0;
                    // next frame starts from empty peaks
                    for (int i = 0; i < PIXEL_NUM; i++) begin
                        bestBin[i] <= '0;
                        bestCount[i] <= '0;
                    end
                end
            end
            // strictly greater, so a tie keeps the earlier bin
            if (updValid && updCount > bestCount[updPixel]) begin
                bestBin[updPixel] <= updBin;
                bestCount[updPixel] <= updCount;
            end
        end
    end

    // tag held for the whole emit sequence
    always_ff @(posedge clk) begin
        if (frameValid) begin
            tagReg <= frameTag;
        end
    end

endmodule

// ==== design/tofHistogram.sv ====
`timescale 1ns/1ns

module tofHistogram import histPkg::*; (
    input  logic               clk,
    input  logic               rstN,
    input  logic               dataValid,
    input  histWord            dataIn,
    output logic               peakValid,
    output logic [PIXEL_W-1:0] peakPixel,
    output logic [BIN_W-1:0]   peakBin,
    output logic [COUNT_W-1:0] peakCount,
    output logic [TAG_W-1:0]   peakFrame,
    output logic               busy
);

    // decoder to accumulator and tracker
    logic               incValid;
    logic [ADDR_W-1:0]  incAddr;
    logic               frameValid;
    logic [TAG_W-1:0]   frameTag;
    // accumulator to memory
    logic               rdEn;
    logic [ADDR_W-1:0]  rdAddr;
    logic [COUNT_W-1:0] rdData;
    logic               wrEn;
    logic [ADDR_W-1:0]  wrAddr;
    logic [COUNT_W-1:0] wrData;
    // accumulator to tracker
    logic               updValid;
    logic [ADDR_W-1:0]  updAddr;
    logic [COUNT_W-1:0] updCount;

    // stage 1, word split
    eventDecoder u_eventDecoder (
        .clk        (clk),
        .rstN       (rstN),
        .dataValid  (dataValid),
        .dataIn     (dataIn),
        .busy       (busy),
        .incValid   (incValid),
        .incAddr    (incAddr),
        .frameValid (frameValid),
        .frameTag   (frameTag)
    );

    // stage 2, count update and clear sweep
    binAccumulator u_binAccumulator (
        .clk        (clk),
        .rstN       (rstN),
        .incValid   (incValid),
        .incAddr    (incAddr),
        .frameValid (frameValid),
        .rdEn       (rdEn),
        .rdAddr     (rdAddr),
        .rdData     (rdData),
        .wrEn       (wrEn),
        .wrAddr     (wrAddr),
        .wrData     (wrData),
        .updValid   (updValid),
        .updAddr    (updAddr),
        .updCount   (updCount),
        .busy       (busy)
    );

    // count storage
    histRam u_histRam (
        .clk    (clk),
        .rdEn   (rdEn),
        .rdAddr (rdAddr),
        .rdData (rdData),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData)
    );

    // stage 3, peaks per pixel
    peakTracker u_peakTracker (
        .clk        (clk),
        .rstN       (rstN),
        .updValid   (updValid),
        .updAddr    (updAddr),
        .updCount   (updCount),
        .frameValid (frameValid),
        .frameTag   (frameTag),
        .peakValid  (peakValid),
        .peakPixel  (peakPixel),
        .peakBin    (peakBin),
        .peakCount  (peakCount),
        .peakFrame  (peakFrame)
    );

endmodule

// ==== verification/tofHistogramTb.sv ====
`timescale 1ns/1ns

module tofHistogramTb import histPkg::*; ();

    logic               clk;
    logic               rstN;
    logic               dataValid;
    histWord            dataIn;
    logic               peakValid;
    logic [PIXEL_W-1:0] peakPixel;
    logic [BIN_W-1:0]   peakBin;
    logic [COUNT_W-1:0] peakCount;
    logic [TAG_W-1:0]   peakFrame;
    logic               busy;
    // two columns per file line, unused slots stay ffff
    logic [15:0] entries [256];
    // reference counts, then best bin and count per pixel
    int modelCount [MEM_DEPTH];
    int bestCount [PIXEL_NUM];
    int bestBin [PIXEL_NUM];
    // peak from the file as bin * 256 + count, -1 if none listed
    int fileExp [PIXEL_NUM];
    logic [TAG_W-1:0] curTag;
    logic [31:0] rngState;
    int peaksSeen;
    int errors;
    int checks;

    tofHistogram DUT (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // four-state compare, an x or z on the DUT side is a mismatch
    task automatic checkValue(input string name, input logic [31:0] expected,
        input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED at %0t ns: %s expected %0d, actual %0d", $time, name, expected,
                actual);
        end
    endtask

    // empty histogram, as after the clear sweep
    task automatic clearModel();
        for (int a = 0; a < MEM_DEPTH; a++) begin
            modelCount[a] = 0;
        end
        for (int p = 0; p < PIXEL_NUM; p++) begin
            bestCount[p] = 0;
            bestBin[p] = 0;
            fileExp[p] = -1;
        end
    endtask

    // one strobe at posedge + 1, then idle cycles
    task automatic sendWord(input logic [WORD_W-1:0] word, input int gap);
        int addr;
        int p;
        addr = word % MEM_DEPTH;
        p = addr / BIN_NUM;
        if (!word[WORD_W-1]) begin
            // saturate at full scale
            if (modelCount[addr] < 255) begin
                modelCount[addr]++;
            end
            // strictly greater, a tie keeps the earlier bin
            if (modelCount[addr] > bestCount[p]) begin
                bestCount[p] = modelCount[addr];
                bestBin[p] = addr % BIN_NUM;
            end
        end else begin
            curTag = word[TAG_W-1:0];
            peaksSeen = 0;
        end
        dataIn = word;
        dataValid = 1'b1;
        @(posedge clk);
        #1;
        dataValid = 1'b0;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    // peak strobes first, then the clear sweep
    task automatic waitFrame();
        int cycles;
        // sweep still running this soon after the marker
        checkValue("busy", 1, busy);
        cycles = 0;
        while (peaksSeen < PIXEL_NUM && cycles < 20) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (peaksSeen < PIXEL_NUM) begin
            errors++;
            $display("only %0d of %0d peak strobes arrived after marker %02h", peaksSeen,
                PIXEL_NUM, curTag);
        end
        cycles = 0;
        while (busy && cycles < 200) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (busy) begin
            errors++;
            $display("busy still high %0d cycles after marker %02h", cycles, curTag);
        end
        clearModel();
    endtask

    // outputs settle by the falling edge
    always @(negedge clk) begin
        if (rstN && peakValid) begin
            if (peaksSeen >= PIXEL_NUM) begin
                errors++;
                $display("extra peak strobe at %0t ns with no marker pending", $time);
            end else begin
                // pixels come out in order 0 to 3
                checkValue("peakPixel", peaksSeen, peakPixel);
                checkValue("peakBin", bestBin[peaksSeen], peakBin);
                checkValue("peakCount", bestCount[peaksSeen], peakCount);
                checkValue("peakFrame", curTag, peakFrame);
                if (fileExp[peaksSeen] >= 0) begin
                    checkValue("peakBin", fileExp[peaksSeen] / 256, peakBin);
                    checkValue("peakCount", fileExp[peaksSeen] % 256, peakCount);
                end
                peaksSeen++;
            end
        end
    end

    initial begin
        int idx;
        int phase;
        int passed;
        int errorsBefore;
        logic [15:0] first;
        logic [15:0] second;
        clk = 1'b0;
        rstN = 1'b0;
        dataValid = 1'b0;
        dataIn = '0;
        curTag = '0;
        rngState = 32'h9d408b0c;
        // no marker sent yet, any strobe counts as extra
        peaksSeen = PIXEL_NUM;
        errors = 0;
        checks = 0;
        idx = 0;
        phase = 0;
        passed = 0;
        errorsBefore = 0;
        for (int i = 0; i < 256; i++) begin
            entries[i] = 16'hffff;
        end
        $readmemh("verification/histInputData.txt", entries);
        clearModel();
        repeat (5) @(posedge clk);
        #1;
        rstN = 1'b1;
        // idle state after reset
        checkValue("busy", 0, busy);
        checkValue("peakValid", 0, peakValid);
        while (idx < 255 && entries[idx] != 16'hffff) begin
            first = entries[idx];
            second = entries[idx + 1];
            idx += 2;
            case (first[15:12])
                // expected peak, pixel and bin in the low byte
                4'h1: fileExp[first[7:4]] = first[3:0] * 256 + second;
                // same word back to back, exercises forwarding
                4'h2: repeat (second) sendWord(first[11:0], 0);
                4'h3: begin
                    repeat (second) begin
                        rngState = xorshift(rngState);
                        // any pixel and bin, gap 0 to 3
                        sendWord({6'b0, rngState[5:0]}, rngState[9:8]);
                    end
                end
                default: begin
                    sendWord(first[11:0], second);
                    // a marker closes the phase
                    if (first[11]) begin
                        waitFrame();
                        if (errors == errorsBefore) begin
                            passed++;
                        end
                        $display("phase %0d, frame %02h: %s", phase, curTag,
                            (errors == errorsBefore) ? "ok" : "failed");
                        phase++;
                        errorsBefore = errors;
                    end
                end
            endcase
        end
        $display("%0d of %0d phases ok, %0d checks, %0d errors", passed, phase, checks, errors);
        if (errors == 0 && phase > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== verification/histInputData.txt ====
// col 1: 0www input word, 10pb expected peak of pixel p in bin b with col 2 as its count
// 2www word www sent col 2 times back to back, 3000 a random burst of col 2 events
// col 2 after an input word: idle cycles
800 02
003 02
017 01
003 01
03a 02
1003 02
1017 01
1020 00
103a 01
811 03
2016 03
2019 03
2025 05
1016 03
1025 05
1000 00
822 02
2037 12c
2030 05
1037 ff
833 02
3000 28
844 00

// ==== vlog.f ====
design/histPkg.sv
design/eventDecoder.sv
design/histRam.sv
design/binAccumulator.sv
design/peakTracker.sv
design/tofHistogram.sv
verification/tofHistogramTb.sv

// ==== Bender.yml ====
package:
  name: tof_histogram

sources:
  - files:
      - design/histPkg.sv
      - design/eventDecoder.sv
      - design/histRam.sv
      - design/binAccumulator.sv
      - design/peakTracker.sv
      - design/tofHistogram.sv
  - target: test
    files:
      - verification/tofHistogramTb.sv
